// ==== hw/bch_gf_pkg.sv ====
package bch_gf_pkg;

	localparam int GF_M_MAX = 8;

	typedef logic [GF_M_MAX-1:0] gf_elem_t;  // Field element, low M bits used
	typedef logic [GF_M_MAX:0]   gf_poly_t;  // Field polynomial incl. x^M term

	// ####################
	// Field constants

	function automatic gf_poly_t gf_prim_poly(int m);
		case (m)
			3:       return gf_poly_t'('h00B);  // x^3+x+1
			4:       return gf_poly_t'('h013);  // x^4+x+1
			5:       return gf_poly_t'('h025);  // x^5+x^2+1
			6:       return gf_poly_t'('h043);  // x^6+x+1
			7:       return gf_poly_t'('h089);  // x^7+x^3+1
			default: return gf_poly_t'('h11D);  // x^8+x^4+x^3+x^2+1
		endcase
	endfunction

	function automatic gf_elem_t gf_mask(int m);
		return gf_elem_t'((1 << m) - 1);
	endfunction

	// ####################
	// Arithmetic

	// MSB-first shift and add, reduced every step
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b, int m);
		gf_poly_t poly;
		gf_poly_t acc;
		poly = gf_prim_poly(m);
		acc  = '0;
		for (int i = GF_M_MAX - 1; i >= 0; i--) begin
			if (i < m) begin
				acc = acc << 1;
				if (acc[m]) begin
					acc = acc ^ poly;  // Fold x^M back in
				end
				if (b[i]) begin
					acc = acc ^ {1'b0, a};
				end
			end
		end
		return acc[GF_M_MAX-1:0];
	endfunction

	// Negative exponents wrap around the group order
	function automatic gf_elem_t gf_alpha_pow(int m, int e);
		int       order;
		int       r;
		gf_elem_t p;
		order = (1 << m) - 1;
		r     = e % order;
		if (r < 0) begin
			r = r + order;
		end
		p = gf_elem_t'(1);
		for (int i = 0; i < r; i++) begin
			p = gf_mul(p, gf_elem_t'(2), m);  // Times alpha
		end
		return p;
	endfunction

endpackage

// ==== hw/bch_code_pkg.sv ====
package bch_code_pkg;

	import bch_gf_pkg::*;

	localparam int T_MAX = 8;    // Largest correction capability
	localparam int N_MAX = 255;  // Longest code, M = 8

	// ####################
	// Decoder vectors

	// S1 sits in element 0
	typedef gf_elem_t [2*T_MAX-1:0] syn_vec_t;

	// Coefficient of x^0 in element 0
	typedef gf_elem_t [T_MAX:0] sigma_vec_t;

	typedef logic [3:0] err_cnt_t;  // Locator degree

	typedef logic [$clog2(N_MAX + 1)-1:0] bit_idx_t;  // Bit position in a word

	// Bit i holds coefficient x^i, first received bit ends up at x^(N-1)
	typedef logic [N_MAX-1:0] cw_buf_t;

	// ####################
	// Output stream

	typedef struct packed {
		logic data;    // Corrected bit
		logic err;     // This bit was flipped
		logic last;    // Final bit of the word
		logic uncorr;  // Word not correctable, valid with last
	} dec_beat_t;

endpackage

// ==== hw/bch_syndrome.sv ====
`timescale 1ns/1ps

module bch_syndrome
	import bch_gf_pkg::*, bch_code_pkg::*;
#(
	parameter int unsigned M = 4,
	parameter int unsigned T = 2
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  logic     in_bit,
	output logic     in_credit,
	input  logic     ready,
	output logic     start,
	output syn_vec_t syndromes,
	output cw_buf_t  codeword
);

	localparam int unsigned N = (1 << M) - 1;

	gf_elem_t s_odd [T];  // S1, S3, ... S(2T-1)
	bit_idx_t bit_cnt;
	logic     full;       // Word complete, waiting on solver
	logic     primed;     // Initial credit already issued
	logic     accept;
	logic     word_end;

	assign accept   = in_valid && !full;
	assign word_end = accept && (bit_cnt == bit_idx_t'(N - 1));
	assign start    = full && ready;

	// ####################
	// Odd syndromes, Horner step per bit

	for (genvar g = 0; g < T; g++) begin : g_odd
		localparam gf_elem_t ALPHA_J = gf_alpha_pow(M, 2 * g + 1);

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				s_odd[g] <= '0;
			end else if (start) begin
				s_odd[g] <= '0;  // Fresh word
			end else if (accept) begin
				s_odd[g] <= gf_mul(s_odd[g], ALPHA_J, M) ^ gf_elem_t'(in_bit);
			end
		end
	end

	// Even ones by squaring, S2j = Sj^2
	always_comb begin
		syndromes = '0;
		for (int k = 1; k <= 2 * T; k++) begin
			if (k % 2 == 1) begin
				syndromes[k-1] = s_odd[(k - 1) / 2];
			end else begin
				syndromes[k-1] = gf_mul(syndromes[k/2-1], syndromes[k/2-1], M);
			end
		end
	end

	// ####################
	// Capture and control

	always_ff @(posedge clk) begin
		if (accept) begin
			codeword <= {codeword[N_MAX-2:0], in_bit};  // MSB first
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt   <= '0;
			full      <= 1'b0;
			primed    <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			primed    <= 1'b1;
			in_credit <= start || !primed;  // Slot freed
			if (start) begin
				full <= 1'b0;
			end else if (word_end) begin
				full <= 1'b1;
			end
			if (word_end) begin
				bit_cnt <= '0;
			end else if (accept) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hw/bch_syndrome_shuffle.sv ====
`timescale 1ns/1ps

module bch_syndrome_shuffle
	import bch_gf_pkg::*, bch_code_pkg::*;
#(
	parameter int unsigned M = 4,
	parameter int unsigned T = 2
) (
	input  logic     clk,
	input  logic     start,
	input  logic     ce,
	input  syn_vec_t syndromes,
	output syn_vec_t syn_shuffled
);

	// Positions 0..T face the sigma taps, the rest wait their turn
	localparam int unsigned RING = 3 * T - 1;

	gf_elem_t ring [RING];

	// Slot 0 gets S1, slots 1..T read as S0, S-1, ... which are zero.
	// S2 .. S(2T-1) are parked at the top and rotate down two per step
	always_ff @(posedge clk) begin
		if (start) begin
			for (int p = 0; p < RING; p++) begin
				ring[p] <= '0;
			end
			ring[0] <= syndromes[0] & gf_mask(M);
			for (int k = 1; k <= 2 * T - 2; k++) begin
				ring[RING-k] <= syndromes[k] & gf_mask(M);  // S(k+1)
			end
		end else if (ce) begin
			for (int p = 0; p < RING; p++) begin
				ring[p] <= ring[(p + RING - 2) % RING];
			end
		end
	end

	always_comb begin
		syn_shuffled = '0;
		for (int i = 0; i <= T; i++) begin
			syn_shuffled[i] = ring[i];  // S(2r-i+1)
		end
	end

endmodule

// ==== hw/bch_sigma_bma.sv ====
`timescale 1ns/1ps

module bch_sigma_bma
	import bch_gf_pkg::*, bch_code_pkg::*;
#(
	parameter int unsigned M = 4,
	parameter int unsigned T = 2
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  syn_vec_t   syndromes,
	input  cw_buf_t    codeword_in,
	input  logic       ack_done,
	output logic       ready,
	output logic       done,
	output sigma_vec_t sigma,
	output err_cnt_t   err_count,
	output cw_buf_t    codeword_out
);

	localparam sigma_vec_t SIGMA_ONE = sigma_vec_t'(1);           // 1
	localparam sigma_vec_t BETA_X    = SIGMA_ONE << GF_M_MAX;     // x

	syn_vec_t   syn_shuffled;
	gf_elem_t   d_r;         // Discrepancy of this iteration
	gf_elem_t   d_p;         // Last nonzero discrepancy
	gf_elem_t   d_next;
	sigma_vec_t beta;
	sigma_vec_t dp_sigma;
	sigma_vec_t dr_beta;
	sigma_vec_t dp_sigma_c;
	sigma_vec_t dr_beta_c;
	sigma_vec_t sigma_x2;
	sigma_vec_t beta_x2;
	err_cnt_t   iter;
	logic       busy;
	logic       phase;       // 0 update, 1 shuffle
	logic       bsel;
	logic       last_iter;

	assign ready     = !busy && (!done || ack_done);
	assign bsel      = (d_r != '0) && (iter >= err_count);
	assign last_iter = (iter == err_cnt_t'(T - 1));

	bch_syndrome_shuffle #(
		.M(M),
		.T(T)
	) u_shuffle (
		.clk         (clk),
		.start       (start),
		.ce          (busy && phase),
		.syndromes   (syndromes),
		.syn_shuffled(syn_shuffled)
	);

	// ####################
	// Parallel multipliers

	always_comb begin
		d_next     = '0;
		dp_sigma_c = '0;
		dr_beta_c  = '0;
		sigma_x2   = '0;
		beta_x2    = '0;
		for (int i = 0; i <= T; i++) begin
			d_next = d_next ^ gf_mul(sigma[i], syn_shuffled[i], M);
		end
		for (int i = 0; i <= T; i++) begin
			dp_sigma_c[i] = gf_mul(d_p, sigma[i], M);
			dr_beta_c[i]  = gf_mul(d_next, beta[i], M);
		end
		for (int i = 2; i <= T; i++) begin
			sigma_x2[i] = sigma[i-2];  // Top terms drop off
			beta_x2[i]  = beta[i-2];
		end
	end

	// ####################
	// Iteration control

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			phase     <= 1'b0;
			iter      <= '0;
			done      <= 1'b0;
			err_count <= '0;
		end else begin
			if (start) begin
				busy      <= 1'b1;
				phase     <= 1'b0;
				iter      <= '0;
				err_count <= '0;
			end else if (busy) begin
				phase <= !phase;
				if (phase) begin
					if (bsel) begin
						err_count <= err_cnt_t'(2 * int'(iter) + 1 - int'(err_count));
					end
					if (last_iter) begin
						busy <= 1'b0;
					end else begin
						iter <= iter + 1'b1;
					end
				end
			end
			if (busy && phase && last_iter) begin
				done <= 1'b1;
			end else if (ack_done) begin
				done <= 1'b0;
			end
		end
	end

	// Polynomial registers
	always_ff @(posedge clk) begin
		if (start) begin
			sigma        <= SIGMA_ONE;
			beta         <= BETA_X;
			d_p          <= gf_elem_t'(1);
			codeword_out <= codeword_in;  // Rides along
		end else if (busy && !phase) begin
			d_r      <= d_next;
			dp_sigma <= dp_sigma_c;
			dr_beta  <= dr_beta_c;
		end else if (busy) begin
			sigma <= dp_sigma ^ dr_beta;  // d_p*sigma - d_r*beta
			if (bsel) begin
				beta <= sigma_x2;
				d_p  <= d_r;
			end else begin
				beta <= beta_x2;
			end
		end
	end

endmodule

// ==== hw/bch_chien_search.sv ====
`timescale 1ns/1ps

module bch_chien_search
	import bch_gf_pkg::*, bch_code_pkg::*;
#(
	parameter int unsigned M           = 4,
	parameter int unsigned T           = 2,
	parameter int unsigned OUT_CREDITS = 4
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       done,
	input  sigma_vec_t sigma,
	input  err_cnt_t   err_count,
	input  cw_buf_t    codeword,
	output logic       ack_done,
	output logic       out_valid,
	output dec_beat_t  out_beat,
	input  logic       out_credit
);

	localparam int unsigned N      = (1 << M) - 1;
	localparam int unsigned CRED_W = $clog2(OUT_CREDITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND,
		ST_STALL
	} state_t;

	state_t            state;
	logic [CRED_W-1:0] credits;
	logic [CRED_W-1:0] credits_next;
	sigma_vec_t        terms;       // sigma_i * alpha^(i*(k+1))
	sigma_vec_t        terms_load;
	sigma_vec_t        terms_step;
	cw_buf_t           cw_q;
	err_cnt_t          err_q;
	err_cnt_t          roots;
	err_cnt_t          roots_next;
	bit_idx_t          beat_idx;
	gf_elem_t          eval_sum;
	logic              root;
	logic              last;
	logic              send;

	for (genvar i = 0; i <= T_MAX; i++) begin : g_term
		if (i <= T) begin : g_used
			localparam gf_elem_t ALPHA_I = gf_alpha_pow(M, i);
			assign terms_load[i] = gf_mul(sigma[i], ALPHA_I, M);
			assign terms_step[i] = gf_mul(terms[i], ALPHA_I, M);
		end else begin : g_zero
			assign terms_load[i] = '0;
			assign terms_step[i] = '0;
		end
	end

	always_comb begin
		eval_sum = '0;
		for (int i = 0; i <= T; i++) begin
			eval_sum = eval_sum ^ terms[i];
		end
	end

	assign root         = (eval_sum == '0);  // Error at x^(N-1-k)
	assign last         = (beat_idx == bit_idx_t'(N - 1));
	assign send         = (state == ST_SEND);
	assign ack_done     = (state == ST_IDLE) && done;
	assign roots_next   = roots + err_cnt_t'(root);
	assign credits_next = credits + CRED_W'(out_credit) - CRED_W'(send);

	assign out_valid       = send;
	assign out_beat.data   = cw_q[N-1] ^ root;
	assign out_beat.err    = root;
	assign out_beat.last   = last;
	assign out_beat.uncorr = last && (roots_next != err_q);

	// ####################
	// Beat FSM and credits

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			credits  <= CRED_W'(OUT_CREDITS);
			beat_idx <= '0;
			roots    <= '0;
		end else begin
			credits <= credits_next;
			case (state)
				ST_IDLE: begin
					if (done) begin
						state    <= (credits_next != '0) ? ST_SEND : ST_STALL;
						beat_idx <= '0;
						roots    <= '0;
					end
				end
				ST_SEND: begin
					beat_idx <= beat_idx + 1'b1;
					roots    <= roots_next;
					if (last) begin
						state <= ST_IDLE;
					end else if (credits_next == '0) begin
						state <= ST_STALL;  // Sink full
					end
				end
				ST_STALL: begin
					if (credits_next != '0) begin
						state <= ST_SEND;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ack_done) begin
			terms <= terms_load;
			cw_q  <= codeword;
			err_q <= err_count;
		end else if (send) begin
			terms <= terms_step;  // Next evaluation point
			cw_q  <= cw_q << 1;
		end
	end

endmodule

// ==== hw/bch_decoder.sv ====
`timescale 1ns/1ps

module bch_decoder
	import bch_code_pkg::*;
#(
	parameter int unsigned M           = 4,  // BCH(15,7)
	parameter int unsigned T           = 2,
	parameter int unsigned OUT_CREDITS = 4   // Sink buffer depth
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      in_valid,
	input  logic      in_bit,
	output logic      in_credit,
	output logic      out_valid,
	output dec_beat_t out_beat,
	input  logic      out_credit
);

	// ####################
	// Stage links

	logic       start;
	logic       ready;
	syn_vec_t   syndromes;
	cw_buf_t    cw_syn;     // Syndrome stage copy
	logic       done;
	logic       ack_done;
	sigma_vec_t sigma;
	err_cnt_t   err_count;
	cw_buf_t    cw_bma;     // Solver stage copy

	bch_syndrome #(
		.M(M),
		.T(T)
	) u_syndrome (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_bit   (in_bit),
		.in_credit(in_credit),
		.ready    (ready),
		.start    (start),
		.syndromes(syndromes),
		.codeword (cw_syn)
	);

	bch_sigma_bma #(
		.M(M),
		.T(T)
	) u_sigma_bma (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (start),
		.syndromes   (syndromes),
		.codeword_in (cw_syn),
		.ack_done    (ack_done),
		.ready       (ready),
		.done        (done),
		.sigma       (sigma),
		.err_count   (err_count),
		.codeword_out(cw_bma)
	);

	bch_chien_search #(
		.M          (M),
		.T          (T),
		.OUT_CREDITS(OUT_CREDITS)
	) u_chien_search (
		.clk       (clk),
		.arst_n    (arst_n),
		.done      (done),
		.sigma     (sigma),
		.err_count (err_count),
		.codeword  (cw_bma),
		.ack_done  (ack_done),
		.out_valid (out_valid),
		.out_beat  (out_beat),
		.out_credit(out_credit)
	);

endmodule

// ==== testbench/tb_bch_decoder.sv ====
`timescale 1ns/1ps

module tb_bch_decoder
	import bch_code_pkg::*;
();

	localparam int M              = 4;
	localparam int T              = 2;
	localparam int OUT_CREDITS    = 4;
	localparam int N              = (1 << M) - 1;
	localparam int GROUP_WORDS    = 40;                // Words per test group
	localparam int NUM_WORDS      = 5 * GROUP_WORDS;
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 60;
	localparam int DRIVE_DLY      = 2;                 // ns after rising edge
	localparam logic [8:0] GEN    = 9'h1D1;            // x^8+x^7+x^6+x^4+1

	typedef struct packed {
		logic [N-1:0] data;    // Original codeword
		logic [N-1:0] err;     // Flipped positions
		logic         triple;  // Three errors, only the codeword rule holds
	} exp_t;

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	logic      in_bit;
	logic      in_credit;
	logic      out_valid;
	dec_beat_t out_beat;
	logic      out_credit;

	exp_t         exp_q[$];              // Scoreboard
	int           due_q[$];              // Cycles at which sink credits go back
	int           cycle           = 0;
	int           credits_granted = 0;
	int           in_bits_seen    = 0;
	int           words_sent      = 0;
	int           words_checked   = 0;
	int           sink_credits    = OUT_CREDITS;
	int           beat_cnt        = 0;
	int           hold_until      = 0;
	bit           stress          = 1'b0;  // Back to back with sink stalls
	logic [N-1:0] got_data;
	logic [N-1:0] got_err;

	bch_decoder #(
		.M          (M),
		.T          (T),
		.OUT_CREDITS(OUT_CREDITS)
	) dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_bit    (in_bit),
		.in_credit (in_credit),
		.out_valid (out_valid),
		.out_beat  (out_beat),
		.out_credit(out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ####################
	// Reference model

	// msg(x) * g(x), bit i is coefficient x^i
	function automatic logic [N-1:0] encode(logic [6:0] msg);
		logic [N-1:0] cw;
		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i]) begin
				cw = cw ^ (N'(GEN) << i);
			end
		end
		return cw;
	endfunction

	function automatic logic [7:0] gen_remainder(logic [N-1:0] word);
		logic [N-1:0] r;
		r = word;
		for (int i = N - 1; i >= 8; i--) begin
			if (r[i]) begin
				r = r ^ (N'(GEN) << (i - 8));
			end
		end
		return r[7:0];
	endfunction

	function automatic logic [N-1:0] error_mask(int count);
		logic [N-1:0] mask;
		mask = '0;
		while ($countones(mask) < count) begin
			mask[$urandom_range(N - 1, 0)] = 1'b1;  // Distinct positions
		end
		return mask;
	endfunction

	// ####################
	// Checking

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped on first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic compare_word(input logic uncorr);
		exp_t e;
		if (exp_q.size() == 0) begin
			fail_run("Decoder produced a word that was never sent");
		end else begin
			e = exp_q.pop_front();
			if (e.triple) begin
				if (!uncorr) begin
					check_equal("out_word_remainder", 32'(gen_remainder(got_data)), 32'd0);
				end
			end else begin
				check_equal("out_beat.data", 32'(got_data), 32'(e.data));
				check_equal("out_beat.err", 32'(got_err), 32'(e.err));
				check_equal("out_beat.uncorr", 32'(uncorr), 32'd0);
			end
			words_checked++;
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Run timed out after %0d cycles with %0d of %0d words checked",
				cycle, words_checked, NUM_WORDS));
		end
	end

	// A credit only follows a fully received word
	always @(posedge clk) begin
		if (in_credit) begin
			check_equal("in_bits_at_credit", 32'(in_bits_seen), 32'(credits_granted * N));
			credits_granted <= credits_granted + 1;
		end
		if (in_valid) begin
			in_bits_seen <= in_bits_seen + 1;
		end
	end

	// ####################
	// Sink with credit return

	always @(posedge clk) begin : sink_model
		int   due;
		logic ret;
		if (out_valid) begin
			check_equal("out_valid_credits", 32'(sink_credits > 0), 32'd1);
			check_equal("out_beat.last", 32'(out_beat.last), 32'(beat_cnt == N - 1));
			got_data[N-1-beat_cnt] = out_beat.data;  // First beat is x^(N-1)
			got_err[N-1-beat_cnt]  = out_beat.err;
			if (beat_cnt == N - 1) begin
				compare_word(out_beat.uncorr);
				beat_cnt = 0;
			end else begin
				beat_cnt++;
			end
			due = cycle + 1 + int'($urandom_range(5, 0));
			if (due_q.size() != 0 && due <= due_q[$]) begin
				due = due_q[$] + 1;  // One pulse per cycle
			end
			due_q.push_back(due);
			if (stress && cycle >= hold_until && $urandom_range(15, 0) == 0) begin
				hold_until = cycle + int'($urandom_range(40, 10));  // Long stall
			end
		end
		sink_credits = sink_credits + int'(out_credit) - int'(out_valid);
		ret = (cycle >= hold_until) && (due_q.size() != 0) && (due_q[0] <= cycle);
		if (ret) begin
			void'(due_q.pop_front());
		end
		#DRIVE_DLY;
		out_credit = ret;
	end

	// ####################
	// Source and test sequence

	task automatic send_word(input logic [N-1:0] word, input bit back_to_back);
		while (words_sent >= credits_granted) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		words_sent++;
		for (int i = N - 1; i >= 0; i--) begin
			if (!back_to_back) begin
				while ($urandom_range(7, 0) == 0) begin
					in_valid = 1'b0;  // Gap in the stream
					@(posedge clk);
					#DRIVE_DLY;
				end
			end
			in_valid = 1'b1;
			in_bit   = word[i];
			@(posedge clk);
			#DRIVE_DLY;
		end
		in_valid = 1'b0;
	endtask

	initial begin
		exp_t         e;
		logic [N-1:0] cw;
		logic [N-1:0] mask;
		int           group;
		int           n_err;
		void'($urandom(32'hf3ad_2748));
		arst_n     = 1'b0;
		in_valid   = 1'b0;
		in_bit     = 1'b0;
		out_credit = 1'b0;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		// Groups of 0, 1, 2 and 3 errors, then a mixed stress group
		for (int w = 0; w < NUM_WORDS; w++) begin
			group  = w / GROUP_WORDS;
			stress = (group == 4);
			n_err  = stress ? int'($urandom_range(2, 0)) : group;
			cw     = encode(7'($urandom));
			mask   = error_mask(n_err);
			e.data   = cw;
			e.err    = mask;
			e.triple = (n_err == 3);
			exp_q.push_back(e);
			send_word(cw ^ mask, stress);
		end
		wait (words_checked == NUM_WORDS);
		repeat (20) @(posedge clk);  // Catch stray beats
		if (exp_q.size() == 0 && beat_cnt == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			fail_run("Decoder output ended in the middle of a word");
		end
	end

endmodule

// ==== all.f ====
hw/bch_gf_pkg.sv
hw/bch_code_pkg.sv
hw/bch_syndrome.sv
hw/bch_syndrome_shuffle.sv
hw/bch_sigma_bma.sv
hw/bch_chien_search.sv
hw/bch_decoder.sv
testbench/tb_bch_decoder.sv

// ==== Bender.yml ====
package:
  name: bch_decoder

dependencies: {}

sources:
  - files:
      - hw/bch_gf_pkg.sv
      - hw/bch_code_pkg.sv
      - hw/bch_syndrome.sv
      - hw/bch_syndrome_shuffle.sv
      - hw/bch_sigma_bma.sv
      - hw/bch_chien_search.sv
      - hw/bch_decoder.sv
  - target: simulation
    files:
      - testbench/tb_bch_decoder.sv
